/* include/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// word and page geometry
`define MMU_XLEN 32
`define MMU_TLB_ENTRIES 16
`define MMU_VPN_W 20
`define MMU_PPN_W 22
`define MMU_OFF_W 12

// cpu privilege modes
`define MMU_CPU_U 2'd0
`define MMU_CPU_S 2'd1
`define MMU_CPU_M 2'd3

// page fault causes
`define MMU_EXC_FETCH_PF 5'd12
`define MMU_EXC_LOAD_PF 5'd13
`define MMU_EXC_STORE_PF 5'd15

// downstream access kind
`define MMU_MEM_READ 1'b0
`define MMU_MEM_WRITE 1'b1

`endif

/* rtl/mmu_pkg.sv */
`include "mmu_macros.svh"

package mmu_pkg;

   typedef struct packed {
      logic [11:0] ppn1;
      logic [9:0]  ppn0;
      logic [1:0]  rsw;
      logic        d;
      logic        a;
      logic        g;
      logic        u;
      logic        x;
      logic        w;
      logic        r;
      logic        v;
   } pte_leaf_t;

   typedef struct packed {
      logic [`MMU_PPN_W-1:0] ppn;
      logic [1:0]            rsw;
      logic [7:0]            flags;
   } pte_ptr_t;

   // same word, read as leaf or as next-level pointer
   typedef union packed {
      pte_leaf_t leaf;
      pte_ptr_t  ptr;
   } pte_u;

   function automatic logic [`MMU_XLEN-1:0] pte_addr(
      input logic [`MMU_PPN_W-1:0] base_ppn,
      input logic [9:0]            idx
   );
      return `MMU_XLEN'({base_ppn, {`MMU_OFF_W{1'b0}}}) + `MMU_XLEN'({idx, 2'b00});
   endfunction

   // superpage takes vpn0 from the virtual address
   function automatic logic [`MMU_PPN_W-1:0] leaf_ppn(
      input pte_u                  pte,
      input logic                  level1,
      input logic [`MMU_XLEN-1:0]  vaddr
   );
      return level1 ? {pte.leaf.ppn1, vaddr[21:12]} : {pte.leaf.ppn1, pte.leaf.ppn0};
   endfunction

   function automatic logic [`MMU_XLEN-1:0] leaf_paddr(
      input pte_u                  pte,
      input logic                  level1,
      input logic [`MMU_XLEN-1:0]  vaddr
   );
      // top two ppn bits fall off the 32-bit address
      return `MMU_XLEN'({leaf_ppn(pte, level1, vaddr), vaddr[`MMU_OFF_W-1:0]});
   endfunction

   function automatic logic [4:0] fault_cause(input logic is_fetch, input logic is_write);
      if (is_fetch) begin
         return `MMU_EXC_FETCH_PF;
      end
      return is_write ? `MMU_EXC_STORE_PF : `MMU_EXC_LOAD_PF;
   endfunction

   function automatic logic translation_off(
      input logic [`MMU_XLEN-1:0] satp,
      input logic [1:0]           cpu_mode
   );
      return !satp[31] || (cpu_mode == `MMU_CPU_M);
   endfunction

endpackage

/* rtl/mmu_ifs.sv */
`include "mmu_macros.svh"

// one request from arbitration to the walker
interface mmu_req_if;
   logic                    valid;
   logic                    ready;
   logic                    is_fetch;
   logic                    is_write;
   logic                    flush;
   logic                    bypass;
   logic [`MMU_XLEN-1:0]    vaddr;
   logic [`MMU_XLEN-1:0]    wdata;
   logic [`MMU_XLEN/8-1:0]  wstrb;

   modport source (output valid, is_fetch, is_write, flush, bypass, vaddr, wdata, wstrb,
                   input ready);
   modport sink (input valid, is_fetch, is_write, flush, bypass, vaddr, wdata, wstrb,
                 output ready);
endinterface

// completion from the walker, one pulse per request
interface mmu_done_if;
   logic                 done;
   logic                 is_fetch;
   logic                 fault;
   logic [4:0]           fault_code;
   logic [`MMU_XLEN-1:0] tval;
   logic [`MMU_XLEN-1:0] rdata;

   modport source (output done, is_fetch, fault, fault_code, tval, rdata);
   modport sink (input done, is_fetch, fault, fault_code, tval, rdata);
endinterface

/* rtl/mmu_req_decode.sv */
`include "mmu_macros.svh"

module mmu_req_decode (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`MMU_XLEN-1:0]   satp,
   input  logic [1:0]             cpu_mode,
   input  logic                   flush_tlb,
   input  logic                   fetch_request_enable,
   input  logic                   freq_mode,
   input  logic [`MMU_XLEN-1:0]   freq_addr,
   input  logic [`MMU_XLEN-1:0]   freq_wdata,
   input  logic [`MMU_XLEN/8-1:0] freq_wstrb,
   input  logic                   mem_request_enable,
   input  logic                   mreq_mode,
   input  logic [`MMU_XLEN-1:0]   mreq_addr,
   input  logic [`MMU_XLEN-1:0]   mreq_wdata,
   input  logic [`MMU_XLEN/8-1:0] mreq_wstrb,
   mmu_req_if.source              req
);

   logic pick;

   assign pick = fetch_request_enable || mem_request_enable;

   always_ff @(posedge clk) begin
      if (rstn) begin
         req.valid <= 1'b0;
      end else begin
         req.valid <= pick && req.ready;
      end
   end

   // fetch wins when both ports fire together
   always_ff @(posedge clk) begin
      if (pick) begin
         req.is_fetch <= fetch_request_enable;
         req.flush    <= flush_tlb;
         req.bypass   <= mmu_pkg::translation_off(satp, cpu_mode);
         if (fetch_request_enable) begin
            req.is_write <= (freq_mode == `MMU_MEM_WRITE);
            req.vaddr    <= freq_addr;
            req.wdata    <= freq_wdata;
            req.wstrb    <= freq_wstrb;
         end else begin
            req.is_write <= (mreq_mode == `MMU_MEM_WRITE);
            req.vaddr    <= mreq_addr;
            req.wdata    <= mreq_wdata;
            req.wstrb    <= mreq_wstrb;
         end
      end
   end

endmodule

/* rtl/mmu_tlb.sv */
`include "mmu_macros.svh"

module mmu_tlb (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  flush,
   input  logic [`MMU_VPN_W-1:0] lookup_vpn,
   output logic                  hit,
   output logic [`MMU_PPN_W-1:0] hit_ppn,
   input  logic                  fill,
   input  logic [`MMU_VPN_W-1:0] fill_vpn,
   input  logic [`MMU_PPN_W-1:0] fill_ppn
);

   localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);

   logic [`MMU_TLB_ENTRIES-1:0] valid_q;
   logic [`MMU_VPN_W-1:0]       tag_q [`MMU_TLB_ENTRIES];
   logic [`MMU_PPN_W-1:0]       ppn_q [`MMU_TLB_ENTRIES];
   logic                        fill_present;
   logic [IDX_W-1:0]            fill_idx;
   logic                        do_fill;

   // lowest matching entry wins
   always_comb begin
      hit     = 1'b0;
      hit_ppn = '0;
      for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
         if (valid_q[i] && (tag_q[i] == lookup_vpn)) begin
            hit     = 1'b1;
            hit_ppn = ppn_q[i];
         end
      end
   end

   // lowest free slot, entry 0 when full
   always_comb begin
      fill_present = 1'b0;
      fill_idx     = '0;
      for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
         if (valid_q[i] && (tag_q[i] == fill_vpn)) begin
            fill_present = 1'b1;
         end
         if (!valid_q[i]) begin
            fill_idx = IDX_W'(i);
         end
      end
   end

   assign do_fill = fill && !fill_present;

   always_ff @(posedge clk) begin
      if (rstn) begin
         valid_q <= '0;
      end else if (flush) begin
         valid_q <= '0;
      end else if (do_fill) begin
         valid_q[fill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_fill) begin
         tag_q[fill_idx] <= fill_vpn;
         ppn_q[fill_idx] <= fill_ppn;
      end
   end

endmodule

/* rtl/mmu_walk.sv */
`include "mmu_macros.svh"

module mmu_walk (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`MMU_XLEN-1:0]   satp,
   input  logic [1:0]             cpu_mode,
   input  logic                   sum,
   mmu_req_if.sink                req,
   output logic                   request_enable,
   output logic                   req_mode,
   output logic [`MMU_XLEN-1:0]   req_addr,
   output logic [`MMU_XLEN-1:0]   req_wdata,
   output logic [`MMU_XLEN/8-1:0] req_wstrb,
   input  logic                   response_enable,
   input  logic [`MMU_XLEN-1:0]   resp_data,
   mmu_done_if.source             done
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_PTE1 = 2'd1;
   localparam logic [1:0] S_PTE2 = 2'd2;
   localparam logic [1:0] S_DATA = 2'd3;

   logic [1:0]            state;
   mmu_pkg::pte_u         pte;
   logic                  level1;
   logic                  is_leaf;
   logic                  pte_bad;
   logic                  u_ok;
   logic                  access_ok;
   logic                  walk_fault;
   logic                  tlb_hit;
   logic [`MMU_PPN_W-1:0] tlb_ppn;
   logic                  tlb_fill;
   logic                  tlb_flush;
   logic [`MMU_XLEN-1:0]  hit_addr;

   assign req.ready = (state == S_IDLE);
   assign pte       = resp_data;
   assign level1    = (state == S_PTE1);
   assign hit_addr  = `MMU_XLEN'({tlb_ppn, req.vaddr[`MMU_OFF_W-1:0]});

   ////////////////////////////////////////////////////
   // pte checks
   always_comb begin
      is_leaf = pte.leaf.r || pte.leaf.x;
      pte_bad = !pte.leaf.v || (!pte.leaf.r && pte.leaf.w);
      if (cpu_mode == `MMU_CPU_U) begin
         u_ok = pte.leaf.u;
      end else begin
         u_ok = !pte.leaf.u || sum;
      end
      if (req.is_fetch) begin
         access_ok = pte.leaf.x;
      end else begin
         access_ok = req.is_write ? pte.leaf.w : pte.leaf.r;
      end
      // superpage must have zero ppn0, pointer at level 0 is a fault
      if (is_leaf) begin
         walk_fault = pte_bad || !u_ok || !access_ok || (level1 && pte.leaf.ppn0 != '0);
      end else begin
         walk_fault = pte_bad || !level1;
      end
   end

   assign tlb_flush = req.valid && req.flush;
   assign tlb_fill  = (state == S_PTE1 || state == S_PTE2) && response_enable &&
                      is_leaf && !walk_fault;

   mmu_tlb mmu_tlb_i (
      .clk        (clk),
      .rstn       (rstn),
      .flush      (tlb_flush),
      .lookup_vpn (req.vaddr[`MMU_XLEN-1:`MMU_OFF_W]),
      .hit        (tlb_hit),
      .hit_ppn    (tlb_ppn),
      .fill       (tlb_fill),
      .fill_vpn   (req.vaddr[`MMU_XLEN-1:`MMU_OFF_W]),
      .fill_ppn   (mmu_pkg::leaf_ppn(pte, level1, req.vaddr))
   );

   ////////////////////////////////////////////////////
   // walk fsm
   always_ff @(posedge clk) begin
      if (rstn) begin
         state          <= S_IDLE;
         request_enable <= 1'b0;
         done.done      <= 1'b0;
         done.fault     <= 1'b0;
      end else begin
         request_enable <= 1'b0;
         done.done      <= 1'b0;
         case (state)
            S_IDLE: begin
               if (req.valid) begin
                  done.is_fetch <= req.is_fetch;
                  request_enable <= !req.flush;
                  if (req.flush) begin
                     done.done  <= 1'b1;
                     done.fault <= 1'b0;
                  end else if (req.bypass || tlb_hit) begin
                     req_mode  <= req.is_write;
                     req_addr  <= req.bypass ? req.vaddr : hit_addr;
                     req_wdata <= req.wdata;
                     req_wstrb <= req.wstrb;
                     state     <= S_DATA;
                  end else begin
                     req_mode <= `MMU_MEM_READ;
                     req_addr <= mmu_pkg::pte_addr(satp[`MMU_PPN_W-1:0], req.vaddr[31:22]);
                     state    <= S_PTE1;
                  end
               end
            end
            S_PTE1, S_PTE2: begin
               if (response_enable) begin
                  if (walk_fault) begin
                     done.done       <= 1'b1;
                     done.fault      <= 1'b1;
                     done.fault_code <= mmu_pkg::fault_cause(req.is_fetch, req.is_write);
                     done.tval       <= req.vaddr;
                     state           <= S_IDLE;
                  end else if (is_leaf) begin
                     request_enable <= 1'b1;
                     req_mode       <= req.is_write;
                     req_addr       <= mmu_pkg::leaf_paddr(pte, level1, req.vaddr);
                     req_wdata      <= req.wdata;
                     req_wstrb      <= req.wstrb;
                     state          <= S_DATA;
                  end else begin
                     request_enable <= 1'b1;
                     req_mode       <= `MMU_MEM_READ;
                     req_addr       <= mmu_pkg::pte_addr(pte.ptr.ppn, req.vaddr[21:12]);
                     state          <= S_PTE2;
                  end
               end
            end
            default: begin
               if (response_enable) begin
                  done.done  <= 1'b1;
                  done.fault <= 1'b0;
                  done.rdata <= resp_data;
                  state      <= S_IDLE;
               end
            end
         endcase
      end
   end

endmodule

/* rtl/mmu_resp.sv */
`include "mmu_macros.svh"

module mmu_resp (
   input  logic                 clk,
   input  logic                 rstn,
   mmu_done_if.sink             done,
   output logic                 fetch_response_enable,
   output logic [`MMU_XLEN-1:0] fresp_data,
   output logic                 mem_response_enable,
   output logic [`MMU_XLEN-1:0] mresp_data,
   output logic                 exception_enable,
   output logic [4:0]           exception_vec,
   output logic [`MMU_XLEN-1:0] exception_tval,
   input  logic                 accept
);

   logic [`MMU_XLEN-1:0] data_out;

   // faulting requests return zero
   assign data_out = done.fault ? '0 : done.rdata;

   always_ff @(posedge clk) begin
      if (rstn) begin
         fetch_response_enable <= 1'b0;
         mem_response_enable   <= 1'b0;
         exception_enable      <= 1'b0;
      end else begin
         fetch_response_enable <= done.done && done.is_fetch;
         mem_response_enable   <= done.done && !done.is_fetch;
         if (done.done && done.fault) begin
            exception_enable <= 1'b1;
         end else if (accept) begin
            exception_enable <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (done.done) begin
         if (done.is_fetch) begin
            fresp_data <= data_out;
         end else begin
            mresp_data <= data_out;
         end
         if (done.fault) begin
            exception_vec  <= done.fault_code;
            exception_tval <= done.tval;
         end
      end
   end

endmodule

/* rtl/mmu_top.sv */
`include "mmu_macros.svh"

module mmu_top (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`MMU_XLEN-1:0]   satp,
   input  logic [1:0]             cpu_mode,
   input  logic                   sum,
   input  logic                   flush_tlb,
   input  logic                   fetch_request_enable,
   input  logic                   freq_mode,
   input  logic [`MMU_XLEN-1:0]   freq_addr,
   input  logic [`MMU_XLEN-1:0]   freq_wdata,
   input  logic [`MMU_XLEN/8-1:0] freq_wstrb,
   output logic                   fetch_response_enable,
   output logic [`MMU_XLEN-1:0]   fresp_data,
   input  logic                   mem_request_enable,
   input  logic                   mreq_mode,
   input  logic [`MMU_XLEN-1:0]   mreq_addr,
   input  logic [`MMU_XLEN-1:0]   mreq_wdata,
   input  logic [`MMU_XLEN/8-1:0] mreq_wstrb,
   output logic                   mem_response_enable,
   output logic [`MMU_XLEN-1:0]   mresp_data,
   output logic [4:0]             exception_vec,
   output logic [`MMU_XLEN-1:0]   exception_tval,
   output logic                   exception_enable,
   output logic                   request_enable,
   output logic                   req_mode,
   output logic [`MMU_XLEN-1:0]   req_addr,
   output logic [`MMU_XLEN-1:0]   req_wdata,
   output logic [`MMU_XLEN/8-1:0] req_wstrb,
   input  logic                   response_enable,
   input  logic [`MMU_XLEN-1:0]   resp_data
);

   mmu_req_if  req_if ();
   mmu_done_if done_if ();

   mmu_req_decode mmu_req_decode_i (
      .clk (clk), .rstn (rstn), .satp (satp), .cpu_mode (cpu_mode), .flush_tlb (flush_tlb),
      .fetch_request_enable (fetch_request_enable), .freq_mode (freq_mode),
      .freq_addr (freq_addr), .freq_wdata (freq_wdata), .freq_wstrb (freq_wstrb),
      .mem_request_enable (mem_request_enable), .mreq_mode (mreq_mode),
      .mreq_addr (mreq_addr), .mreq_wdata (mreq_wdata), .mreq_wstrb (mreq_wstrb),
      .req (req_if.source)
   );

   mmu_walk mmu_walk_i (
      .clk (clk), .rstn (rstn), .satp (satp), .cpu_mode (cpu_mode), .sum (sum),
      .req (req_if.sink), .request_enable (request_enable), .req_mode (req_mode),
      .req_addr (req_addr), .req_wdata (req_wdata), .req_wstrb (req_wstrb),
      .response_enable (response_enable), .resp_data (resp_data), .done (done_if.source)
   );

   mmu_resp mmu_resp_i (
      .clk (clk), .rstn (rstn), .done (done_if.sink),
      .fetch_response_enable (fetch_response_enable), .fresp_data (fresp_data),
      .mem_response_enable (mem_response_enable), .mresp_data (mresp_data),
      .exception_enable (exception_enable), .exception_vec (exception_vec),
      .exception_tval (exception_tval), .accept (req_if.valid)
   );

endmodule

/* dv/mmu_tb.sv */
`include "mmu_macros.svh"

module mmu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SATP_ON    = 32'h8000_0010;
   localparam logic [31:0] SATP_OFF   = 32'h0000_0010;
   localparam logic [31:0] DATA_KEY   = 32'hA5A5_5A5A;
   localparam int          MEM_DELAY  = 3;
   localparam int          WAIT_LIMIT = 100;

   typedef struct {
      string       name;
      bit          fetch;
      bit          write;
      logic [31:0] vaddr;
      logic [1:0]  cpu;
      bit          sum;
      logic [31:0] satp;
      bit          flush;
      logic [31:0] exp_addr;
      bit          fault;
      logic [4:0]  code;
      int          count;
   } case_t;

   logic        clk;
   logic        rstn;
   logic [31:0] satp;
   logic [1:0]  cpu_mode;
   logic        sum;
   logic        flush_tlb;
   logic        fetch_request_enable;
   logic        freq_mode;
   logic [31:0] freq_addr;
   logic [31:0] freq_wdata;
   logic [3:0]  freq_wstrb;
   logic        fetch_response_enable;
   logic [31:0] fresp_data;
   logic        mem_request_enable;
   logic        mreq_mode;
   logic [31:0] mreq_addr;
   logic [31:0] mreq_wdata;
   logic [3:0]  mreq_wstrb;
   logic        mem_response_enable;
   logic [31:0] mresp_data;
   logic [4:0]  exception_vec;
   logic [31:0] exception_tval;
   logic        exception_enable;
   logic        request_enable;
   logic        req_mode;
   logic [31:0] req_addr;
   logic [31:0] req_wdata;
   logic [3:0]  req_wstrb;
   logic        response_enable;
   logic [31:0] resp_data;

   case_t       cases[$];
   int          errors;
   int          seed;
   int          pend;
   int          req_total;
   logic [31:0] last_addr;
   logic        last_mode;
   logic [31:0] last_wdata;
   logic [3:0]  last_wstrb;

   mmu_top mmu_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // page table memory

   function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
      return {ppn, 2'b00, flags};
   endfunction

   // root table at 0x10000, level-0 table at 0x11000
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      case (addr)
         32'h0001_0004: return make_pte(22'h00011, 8'h01);
         32'h0001_0008: return make_pte(22'h00C00, 8'hCF);
         32'h0001_000C: return make_pte(22'h00C01, 8'hCF);
         32'h0001_0010: return 32'h0;
         32'h0001_1000: return make_pte(22'h0A0C5, 8'hCF);
         32'h0001_1004: return make_pte(22'h0B001, 8'h43);
         32'h0001_1008: return make_pte(22'h0B002, 8'h05);
         32'h0001_1010: return make_pte(22'h00012, 8'h01);
         32'h0001_1014: return make_pte(22'h0C002, 8'hDF);
         default: return addr ^ DATA_KEY;
      endcase
   endfunction

   // answers each request after a fixed delay
   initial begin
      response_enable = 1'b0;
      resp_data       = '0;
      pend            = 0;
      req_total       = 0;
      last_addr       = '0;
      last_mode       = 1'b0;
      last_wdata      = '0;
      last_wstrb      = '0;
      forever begin
         @(negedge clk);
         response_enable = 1'b0;
         if (pend > 0) begin
            pend--;
            if (pend == 0) begin
               response_enable = 1'b1;
               resp_data       = mem_word(last_addr);
            end
         end
         if (request_enable) begin
            last_addr  = req_addr;
            last_mode  = req_mode;
            last_wdata = req_wdata;
            last_wstrb = req_wstrb;
            pend       = MEM_DELAY;
            req_total++;
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus table and checks

   task automatic add_case(input string name, input int fetch, input int write,
                           input logic [31:0] vaddr, input logic [1:0] cpu, input int sum,
                           input logic [31:0] satp, input int flush, input logic [31:0] exp_addr,
                           input int fault, input logic [4:0] code, input int count);
      case_t c;
      c.name     = name;
      c.fetch    = (fetch != 0);
      c.write    = (write != 0);
      c.vaddr    = vaddr;
      c.cpu      = cpu;
      c.sum      = (sum != 0);
      c.satp     = satp;
      c.flush    = (flush != 0);
      c.exp_addr = exp_addr;
      c.fault    = (fault != 0);
      c.code     = code;
      c.count    = count;
      cases.push_back(c);
   endtask

   task automatic build_table;
      // name, fetch, write, vaddr, cpu, sum, satp, flush, paddr, fault, code, requests
      add_case("bypass_off", 0, 0, 'h00002468, `MMU_CPU_S, 0, SATP_OFF, 0, 'h00002468, 0, 5'd0, 1);
      add_case("bypass_m", 0, 1, 'h12345678, `MMU_CPU_M, 0, SATP_ON, 0, 'h12345678, 0, 5'd0, 1);
      add_case("u_on_s_page", 0, 0, 'h00400ABC, `MMU_CPU_U, 0, SATP_ON, 0, 'h0, 1, 5'd13, 2);
      add_case("walk_l0", 0, 0, 'h00400ABC, `MMU_CPU_S, 0, SATP_ON, 0, 'h0A0C5ABC, 0, 5'd0, 3);
      add_case("tlb_hit", 0, 0, 'h00400123, `MMU_CPU_S, 0, SATP_ON, 0, 'h0A0C5123, 0, 5'd0, 1);
      add_case("flush", 0, 0, 'h00400123, `MMU_CPU_S, 0, SATP_ON, 1, 'h0, 0, 5'd0, 0);
      add_case("rewalk", 0, 0, 'h00400123, `MMU_CPU_S, 0, SATP_ON, 0, 'h0A0C5123, 0, 5'd0, 3);
      add_case("fetch_flush", 1, 0, 'h00400123, `MMU_CPU_S, 0, SATP_ON, 1, 'h0, 0, 5'd0, 0);
      add_case("fetch_walk", 1, 0, 'h00400123, `MMU_CPU_S, 0, SATP_ON, 0, 'h0A0C5123, 0, 5'd0, 3);
      add_case("superpage", 0, 0, 'h00A34567, `MMU_CPU_S, 0, SATP_ON, 0, 'h00E34567, 0, 5'd0, 2);
      add_case("invalid_pte", 0, 0, 'h01000000, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd13, 1);
      add_case("w_no_r", 0, 0, 'h00402000, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd13, 2);
      add_case("misaligned", 0, 1, 'h00C01000, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd15, 1);
      add_case("l0_pointer", 0, 0, 'h00404000, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd13, 2);
      add_case("store_no_w", 0, 1, 'h00401100, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd15, 2);
      add_case("fetch_no_x", 1, 0, 'h00401100, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd12, 2);
      add_case("fetch_ok", 1, 0, 'h00A00040, `MMU_CPU_S, 0, SATP_ON, 0, 'h00E00040, 0, 5'd0, 2);
      add_case("s_no_sum", 0, 0, 'h00405010, `MMU_CPU_S, 0, SATP_ON, 0, 'h0, 1, 5'd13, 2);
      add_case("u_page", 0, 0, 'h00405010, `MMU_CPU_U, 0, SATP_ON, 0, 'h0C002010, 0, 5'd0, 3);
      add_case("store_super", 0, 1, 'h00A35004, `MMU_CPU_S, 0, SATP_ON, 0, 'h00E35004, 0, 5'd0, 2);
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("MISMATCH %s %s: expected %h actual %h", name, what, expected, actual);
      errors++;
   endtask

   task automatic run_case(input case_t c);
      int          cycles;
      int          count0;
      logic [31:0] exp_data;
      logic [31:0] got_data;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      wdata = $random(seed);
      wstrb = 4'($random(seed));
      @(negedge clk);
      satp                 = c.satp;
      cpu_mode             = c.cpu;
      sum                  = c.sum;
      flush_tlb            = c.flush;
      freq_mode            = c.write;
      mreq_mode            = c.write;
      freq_addr            = c.vaddr;
      mreq_addr            = c.vaddr;
      freq_wdata           = wdata;
      mreq_wdata           = wdata;
      freq_wstrb           = wstrb;
      mreq_wstrb           = wstrb;
      fetch_request_enable = c.fetch;
      mem_request_enable   = !c.fetch;
      count0               = req_total;
      @(negedge clk);
      fetch_request_enable = 1'b0;
      mem_request_enable   = 1'b0;
      flush_tlb            = 1'b0;
      cycles               = 0;
      while (!fetch_response_enable && !mem_response_enable && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!fetch_response_enable && !mem_response_enable) begin
         $display("%s: no response strobe within %0d cycles", c.name, WAIT_LIMIT);
         errors++;
      end else begin
         exp_data = c.fault ? '0 : c.exp_addr ^ DATA_KEY;
         got_data = c.fetch ? fresp_data : mresp_data;
         if (fetch_response_enable != c.fetch || mem_response_enable == c.fetch) begin
            $display("%s: response strobe came on the wrong port", c.name);
            errors++;
         end
         if (!c.flush && got_data !== exp_data) begin
            report_mismatch(c.name, "data", exp_data, got_data);
         end
         if (exception_enable !== c.fault) begin
            report_mismatch(c.name, "exception_enable", 32'(c.fault), 32'(exception_enable));
         end
         if (c.fault && exception_vec !== c.code) begin
            report_mismatch(c.name, "exception_vec", 32'(c.code), 32'(exception_vec));
         end
         if (c.fault && exception_tval !== c.vaddr) begin
            report_mismatch(c.name, "exception_tval", c.vaddr, exception_tval);
         end
         if (req_total - count0 != c.count) begin
            report_mismatch(c.name, "requests", 32'(c.count), 32'(req_total - count0));
         end
         if (!c.fault && c.count > 0 && last_addr !== c.exp_addr) begin
            report_mismatch(c.name, "req_addr", c.exp_addr, last_addr);
         end
         // the data access carries the request's own kind, data and strobes
         if (!c.fault && c.count > 0 && last_mode !== c.write) begin
            report_mismatch(c.name, "req_mode", 32'(c.write), 32'(last_mode));
         end
         if (!c.fault && c.count > 0 && last_wdata !== wdata) begin
            report_mismatch(c.name, "req_wdata", wdata, last_wdata);
         end
         if (!c.fault && c.count > 0 && last_wstrb !== wstrb) begin
            report_mismatch(c.name, "req_wstrb", 32'(wstrb), 32'(last_wstrb));
         end
      end
   endtask

   initial begin
      errors               = 0;
      seed                 = 10;
      rstn                 = 1'b1;
      satp                 = '0;
      cpu_mode             = `MMU_CPU_M;
      sum                  = 1'b0;
      flush_tlb            = 1'b0;
      fetch_request_enable = 1'b0;
      freq_mode            = `MMU_MEM_READ;
      freq_addr            = '0;
      freq_wdata           = '0;
      freq_wstrb           = 4'hF;
      mem_request_enable   = 1'b0;
      mreq_mode            = `MMU_MEM_READ;
      mreq_addr            = '0;
      mreq_wdata           = '0;
      mreq_wstrb           = 4'hF;
      build_table();
      repeat (4) @(negedge clk);
      rstn = 1'b0;
      foreach (cases[i]) begin
         run_case(cases[i]);
      end
      $display("cases %0d, errors %0d", cases.size(), errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* dv/mmu_assert.sv */
`include "mmu_macros.svh"

module mmu_assert (
   input logic                 clk,
   input logic                 rstn,
   input logic                 fetch_response_enable,
   input logic                 mem_response_enable,
   input logic                 request_enable,
   input logic [`MMU_XLEN-1:0] req_addr
);
   timeunit 1ns;
   timeprecision 1ps;

   one_port_a: assert property (@(posedge clk) disable iff (rstn)
      !(fetch_response_enable && mem_response_enable))
      else $error("fetch and mem response strobes high together");

   // single-cycle strobes
   fetch_pulse_a: assert property (@(posedge clk) disable iff (rstn)
      fetch_response_enable |=> !fetch_response_enable)
      else $error("fetch_response_enable held longer than one cycle");

   mem_pulse_a: assert property (@(posedge clk) disable iff (rstn)
      mem_response_enable |=> !mem_response_enable)
      else $error("mem_response_enable held longer than one cycle");

   req_pulse_a: assert property (@(posedge clk) disable iff (rstn)
      request_enable |=> !request_enable)
      else $error("request_enable held longer than one cycle");

   addr_stable_a: assert property (@(posedge clk) disable iff (rstn)
      request_enable |=> $stable(req_addr))
      else $error("req_addr changed right after request_enable");

endmodule

bind mmu_top mmu_assert mmu_assert_i (
   .clk                   (clk),
   .rstn                  (rstn),
   .fetch_response_enable (fetch_response_enable),
   .mem_response_enable   (mem_response_enable),
   .request_enable        (request_enable),
   .req_addr              (req_addr)
);

/* vlog.f */
+incdir+include
rtl/mmu_pkg.sv
rtl/mmu_ifs.sv
rtl/mmu_req_decode.sv
rtl/mmu_tlb.sv
rtl/mmu_walk.sv
rtl/mmu_resp.sv
rtl/mmu_top.sv
dv/mmu_tb.sv
dv/mmu_assert.sv

/* run.sh */
#!/bin/sh
# build and run the MMU testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f vlog.f --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/mmu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1
